/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= blink_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Verification passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
source/blink_pkg.sv
source/blink_io_if.sv
source/bank_mapper.sv
source/rtc_timer.sv
source/key_matrix.sv
source/io_regs.sv
source/int_ctrl.sv
source/blink_top.sv
tests/blink_tb.sv

/* source/bank_mapper.sv */
module bank_mapper (
  input  logic [15:0]      ca,
  input  logic             mrq_n,
  input  logic             crd_n,
  input  logic [3:0][7:0]  sr,
  input  logic             rams,
  output logic [21:0]      ma,
  output logic             ipce_n,
  output logic             irce_n,
  output logic             se1_n,
  output logic             se2_n,
  output logic             se3_n,
  output logic             roe_n,
  output logic             wrb_n
);

  logic mem;  // Memory cycle in progress

  assign mem = !mrq_n;

  // Logical to physical, top two bits pick the segment
  always_comb begin
    case (ca[15:14])
      2'b11:   ma = {sr[3], ca[13:0]};  // C000-FFFF
      2'b10:   ma = {sr[2], ca[13:0]};  // 8000-BFFF
      2'b01:   ma = {sr[1], ca[13:0]};  // 4000-7FFF
      default: begin
        if (ca[13])
          ma = {sr[0], 1'b1, ca[12:0]};  // 2000-3FFF, upper half of bank
        else if (rams)
          ma = {blink_pkg::RAMS_BANK, 1'b0, ca[12:0]};  // RAM at reset vectors
        else
          ma = {8'h00, 1'b0, ca[12:0]};  // Boot ROM
      end
    endcase
  end

  // Slot 0 split into ROM and RAM halves
  assign ipce_n = !(mem && ma[21:19] == 3'b000);
  assign irce_n = !(mem && ma[21:19] == 3'b001);
  assign se1_n  = !(mem && ma[21:20] == 2'b01);
  assign se2_n  = !(mem && ma[21:20] == 2'b10);
  assign se3_n  = !(mem && ma[21:20] == 2'b11);
  assign roe_n  = !(mem && !crd_n);
  assign wrb_n  = !(mem && crd_n);

endmodule

/* source/blink_io_if.sv */
interface blink_io_if;

  logic                 wr;        // Write cycle, every cycle of it
  logic                 rd_start;  // First cycle of a read
  logic                 rd_end;    // Cycle after ior_n rose
  logic                 intack;    // Interrupt acknowledge cycle
  blink_pkg::io_port_e  port;      // Low address byte
  logic [7:0]           wdata;

  // Decoder side
  modport dec (output wr, rd_start, rd_end, intack, port, wdata);

  // Register block side
  modport dev (input wr, rd_start, rd_end, intack, port, wdata);

endinterface

/* source/blink_pkg.sv */
package blink_pkg;

  // Z80 I/O ports answered by the gate array
  // Read and write share numbers, direction comes from crd_n
  typedef enum logic [7:0] {
    PORT_COM       = 8'hB0,  // Common control, write
    PORT_INT_STA   = 8'hB1,  // INT write, STA read
    PORT_KBD       = 8'hB2,  // Keyboard column read
    PORT_TACK      = 8'hB4,  // Timer flag ack, write
    PORT_TMK_TSTA  = 8'hB5,  // TMK write, TSTA read
    PORT_ACK       = 8'hB6,  // Interrupt ack, write
    PORT_SR0_TIM0  = 8'hD0,
    PORT_SR1_TIM1  = 8'hD1,
    PORT_SR2_TIMM0 = 8'hD2,  // Minutes bits 7:0 on read
    PORT_SR3_TIMM1 = 8'hD3,  // Minutes bits 15:8 on read
    PORT_TIMM2     = 8'hD4   // Minutes bits 20:16, read only
  } io_port_e;

  // Highest unit advanced by the RTC on one divider wrap
  typedef enum logic [1:0] {
    TICK_NONE,
    TICK_5MS,
    TICK_SEC,
    TICK_MIN
  } tick_e;

  // mck cycles per 5 ms tick at 9.8304 MHz
  localparam int TICK_DIV_DEF = 49152;

  // Counter wrap points
  localparam logic [7:0] TIM0_MAX = 8'd199;  // 200 x 5 ms
  localparam logic [5:0] TIM1_MAX = 6'd59;   // 60 seconds

  // Bank mapped into 0000-1FFF when RAMS is set
  localparam logic [7:0] RAMS_BANK = 8'h20;

  // COM bits
  localparam int COM_RAMS   = 2;
  localparam int COM_RESTIM = 4;

  // INT bits
  localparam int INT_GINT  = 0;  // Global enable
  localparam int INT_TIME  = 1;  // RTC interrupt enable
  localparam int INT_KWAIT = 7;  // Snooze on empty KBD read

endpackage

/* source/blink_top.sv */
module blink_top #(
  parameter int tick_div = blink_pkg::TICK_DIV_DEF
) (
  input  logic         mck,
  input  logic         rst,
  input  logic [15:0]  ca,
  input  logic [7:0]   cdi,
  output logic [7:0]   cdo,
  input  logic         mrq_n,
  input  logic         ior_n,
  input  logic         crd_n,
  input  logic         cm1_n,
  input  logic         hlt_n,
  input  logic [63:0]  kbmat,
  output logic [21:0]  ma,
  output logic         ipce_n,
  output logic         irce_n,
  output logic         se1_n,
  output logic         se2_n,
  output logic         se3_n,
  output logic         roe_n,
  output logic         wrb_n,
  output logic         intb_n,
  output logic         pm1
);

  blink_pkg::tick_e tick;
  logic [7:0]       tim0;
  logic [5:0]       tim1;
  logic [20:0]      timm;
  logic [7:0]       com;
  logic [3:0][7:0]  sr;
  logic [7:0]       sta;
  logic [2:0]       tsta;
  logic [7:0]       kbd;
  logic             key_any;
  logic             clk_run;

  blink_io_if io_bus ();

  io_regs io_regs_i (
    .mck, .rst, .ca(ca[7:0]), .cdi, .cdo, .ior_n, .crd_n, .cm1_n,
    .kbd, .tim0, .tim1, .timm, .sta, .tsta, .com, .sr, .io(io_bus.dec)
  );

  int_ctrl int_ctrl_i (
    .mck, .rst, .io(io_bus.dev), .tick, .key_any, .hlt_n,
    .sta, .tsta, .intb_n, .clk_run
  );

  rtc_timer #(.tick_div(tick_div)) rtc_timer_i (
    .mck, .rst, .restim(com[blink_pkg::COM_RESTIM]), .tick, .tim0, .tim1, .timm
  );

  key_matrix key_matrix_i (.row_sel(ca[15:8]), .kbmat, .kbd, .key_any);

  bank_mapper bank_mapper_i (
    .ca, .mrq_n, .crd_n, .sr, .rams(com[blink_pkg::COM_RAMS]),
    .ma, .ipce_n, .irce_n, .se1_n, .se2_n, .se3_n, .roe_n, .wrb_n
  );

  assign pm1 = mck & clk_run;  // Gated Z80 clock

endmodule

/* source/int_ctrl.sv */
module int_ctrl (
  input  logic              mck,
  input  logic              rst,
  blink_io_if.dev           io,
  input  blink_pkg::tick_e  tick,
  input  logic              key_any,
  input  logic              hlt_n,
  output logic [7:0]        sta,
  output logic [2:0]        tsta,
  output logic              intb_n,
  output logic              clk_run   // CPU clock switch
);

  logic [7:0] int_r;      // INT register
  logic [2:0] tmk;        // Timer masks
  logic       intb;
  logic       iak;        // STA read pending auto ack
  logic       snooze;     // Waiting on a key
  logic       snooze_set;
  logic [2:0] tick_code;  // TSTA pattern for this tick
  logic       tick_int;   // Unmasked timer event

  always_comb begin
    case (tick)
      blink_pkg::TICK_5MS: tick_code = 3'b001;
      blink_pkg::TICK_SEC: tick_code = 3'b011;
      blink_pkg::TICK_MIN: tick_code = 3'b111;
      default:             tick_code = 3'b000;
    endcase
  end

  // Mask bit of the highest unit only
  assign tick_int = int_r[blink_pkg::INT_GINT] && int_r[blink_pkg::INT_TIME]
                    && |(tmk & (tick_code ^ {1'b0, tick_code[2:1]}));

  // Empty KBD read in KWAIT mode
  assign snooze_set = io.rd_start && io.port == blink_pkg::PORT_KBD
                      && int_r[blink_pkg::INT_KWAIT] && !key_any;

  always_ff @(posedge mck) begin
    if (rst) begin
      int_r   <= '0;
      tmk     <= '0;
      tsta    <= '0;
      sta     <= '0;
      intb    <= 1'b0;
      iak     <= 1'b0;
      snooze  <= 1'b0;
      clk_run <= 1'b1;
    end else begin
      if (io.wr) begin
        case (io.port)
          blink_pkg::PORT_INT_STA:  int_r <= io.wdata;
          blink_pkg::PORT_TMK_TSTA: tmk   <= io.wdata[2:0];
          blink_pkg::PORT_TACK:     tsta  <= tsta & ~io.wdata[2:0];
          blink_pkg::PORT_ACK:      sta   <= sta & ~io.wdata;
          default: ;
        endcase
      end
      if (io.rd_start && io.port == blink_pkg::PORT_INT_STA)
        iak <= 1'b1;
      if (io.rd_end && iak) begin  // Auto ack of the timer flag
        sta[2] <= 1'b0;
        iak    <= 1'b0;
      end
      if (io.intack)
        intb <= 1'b0;
      if (snooze_set)
        snooze <= 1'b1;
      else if (snooze && key_any) begin  // Key wakes the CPU
        snooze <= 1'b0;
        intb   <= 1'b1;
      end
      if (tick != blink_pkg::TICK_NONE) begin
        tsta <= tsta | tick_code;
        if (tick_int) begin
          sta[2] <= 1'b1;
          intb   <= 1'b1;
        end
      end
      // Interrupt restarts, halt or snooze stops
      if (intb)
        clk_run <= 1'b1;
      else if (!hlt_n || snooze || snooze_set)
        clk_run <= 1'b0;
    end
  end

  assign intb_n = !intb;

endmodule

/* source/io_regs.sv */
module io_regs (
  input  logic             mck,
  input  logic             rst,
  input  logic [7:0]       ca,     // Port number
  input  logic [7:0]       cdi,
  output logic [7:0]       cdo,
  input  logic             ior_n,
  input  logic             crd_n,
  input  logic             cm1_n,
  input  logic [7:0]       kbd,
  input  logic [7:0]       tim0,
  input  logic [5:0]       tim1,
  input  logic [20:0]      timm,
  input  logic [7:0]       sta,
  input  logic [2:0]       tsta,
  output logic [7:0]       com,
  output logic [3:0][7:0]  sr,
  blink_io_if.dec          io
);

  logic       ior_q;    // ior_n one cycle back
  logic       rd_act;   // Read in progress
  logic       rd_end_r;
  logic [7:0] rd_data;  // Latched read value

  // Cycle decode, M1 marks an interrupt acknowledge
  assign io.wr       = !ior_n && crd_n && cm1_n;
  assign io.rd_start = !ior_n && !crd_n && cm1_n && ior_q;
  assign io.rd_end   = rd_end_r;
  assign io.intack   = !ior_n && !cm1_n;
  assign io.port     = blink_pkg::io_port_e'(ca);
  assign io.wdata    = cdi;

  always_ff @(posedge mck) begin
    if (rst) begin
      ior_q    <= 1'b1;
      rd_act   <= 1'b0;
      rd_end_r <= 1'b0;
    end else begin
      ior_q    <= ior_n;
      rd_end_r <= rd_act && ior_n;  // Read finished last cycle
      if (io.rd_start)
        rd_act <= 1'b1;
      else if (ior_n)
        rd_act <= 1'b0;
    end
  end

  // Control and bank registers
  always_ff @(posedge mck) begin
    if (rst) begin
      com <= '0;
      sr  <= '0;
    end else if (io.wr) begin
      case (io.port)
        blink_pkg::PORT_COM:       com   <= cdi;
        blink_pkg::PORT_SR0_TIM0:  sr[0] <= cdi;
        blink_pkg::PORT_SR1_TIM1:  sr[1] <= cdi;
        blink_pkg::PORT_SR2_TIMM0: sr[2] <= cdi;
        blink_pkg::PORT_SR3_TIMM1: sr[3] <= cdi;
        default: ;  // Owned by int_ctrl
      endcase
    end
  end

  // Sample once at read start, hold for the rest of the cycle
  always_ff @(posedge mck) begin
    if (io.rd_start) begin
      case (io.port)
        blink_pkg::PORT_INT_STA:   rd_data <= sta;
        blink_pkg::PORT_KBD:       rd_data <= kbd;
        blink_pkg::PORT_TMK_TSTA:  rd_data <= {5'b00000, tsta};
        blink_pkg::PORT_SR0_TIM0:  rd_data <= tim0;
        blink_pkg::PORT_SR1_TIM1:  rd_data <= {2'b00, tim1};
        blink_pkg::PORT_SR2_TIMM0: rd_data <= timm[7:0];
        blink_pkg::PORT_SR3_TIMM1: rd_data <= timm[15:8];
        blink_pkg::PORT_TIMM2:     rd_data <= {3'b000, timm[20:16]};
        default:                   rd_data <= 8'hFF;  // Floating bus
      endcase
    end
  end

  assign cdo = ior_n ? cdi : rd_data;  // Pass-through outside I/O reads

  // Z80 holds every I/O strobe for at least two clocks
  strobe_hold: assert property (@(posedge mck) disable iff (rst)
    $fell(ior_n) |=> !ior_n)
    else $error("io_regs: ior_n held low for a single clock");

endmodule

/* source/key_matrix.sv */
module key_matrix (
  input  logic [7:0]   row_sel,  // High address byte, one bit per row
  input  logic [63:0]  kbmat,    // Row r in bits 8r+7..8r
  output logic [7:0]   kbd,
  output logic         key_any
);

  logic [7:0] row_byte [8];

  // Unselected rows contribute nothing
  always_comb begin
    for (int r = 0; r < 8; r++) begin
      row_byte[r] = row_sel[r] ? kbmat[8*r +: 8] : 8'h00;
    end
  end

  // Merge of all selected rows
  always_comb begin
    kbd = 8'h00;
    for (int r = 0; r < 8; r++) begin
      kbd = kbd | row_byte[r];
    end
  end

  assign key_any = |kbd;  // Any key in the selected rows

endmodule

/* source/rtc_timer.sv */
module rtc_timer #(
  parameter int tick_div = blink_pkg::TICK_DIV_DEF
) (
  input  logic                mck,
  input  logic                rst,
  input  logic                restim,
  output blink_pkg::tick_e    tick,
  output logic [7:0]          tim0,
  output logic [5:0]          tim1,
  output logic [20:0]         timm
);

  localparam int DIV_W = $clog2(tick_div);

  logic [DIV_W-1:0] div;  // Free running 5 ms prescaler
  logic             wrap;

  assign wrap = (div == DIV_W'(tick_div - 1));

  // Divider ignores restim
  always_ff @(posedge mck) begin
    if (rst)
      div <= '0;
    else if (wrap)
      div <= '0;
    else
      div <= div + 1'b1;
  end

  always_ff @(posedge mck) begin
    if (rst || restim) begin  // Held clear, no events
      tim0 <= '0;
      tim1 <= '0;
      timm <= '0;
      tick <= blink_pkg::TICK_NONE;
    end else if (wrap) begin
      if (tim0 != blink_pkg::TIM0_MAX) begin
        tim0 <= tim0 + 1'b1;
        tick <= blink_pkg::TICK_5MS;
      end else begin
        tim0 <= '0;
        if (tim1 != blink_pkg::TIM1_MAX) begin
          tim1 <= tim1 + 1'b1;
          tick <= blink_pkg::TICK_SEC;
        end else begin
          tim1 <= '0;
          timm <= timm + 1'b1;  // Wraps after 2^21 minutes
          tick <= blink_pkg::TICK_MIN;
        end
      end
    end else begin
      tick <= blink_pkg::TICK_NONE;  // One cycle pulse
    end
  end

endmodule

/* tests/blink_tb.sv */
module blink_tb;

  localparam int TICK_DIV   = 16;  // Short 5 ms tick for simulation
  localparam int CLK_PERIOD = 4;

  typedef enum {OP_WR, OP_RD, OP_MEM, OP_KEY, OP_TICKS} op_e;

  typedef struct {
    op_e         op;
    logic [7:0]  port;  // Port, or low address byte
    logic [7:0]  hi;    // High address byte, KBD row select
    logic [7:0]  data;  // Write data or tick count
    logic [24:0] exp;   // Read byte, or enable index over ma
  } entry_t;

  logic        mck;
  logic        rst;
  logic [15:0] ca;
  logic [7:0]  cdi;
  logic [7:0]  cdo;
  logic        mrq_n;
  logic        ior_n;
  logic        crd_n;
  logic        cm1_n;
  logic        hlt_n;
  logic [63:0] kbmat;
  logic [21:0] ma;
  logic        ipce_n;
  logic        irce_n;
  logic        se1_n;
  logic        se2_n;
  logic        se3_n;
  logic        roe_n;
  logic        wrb_n;
  logic        intb_n;
  logic        pm1;

  entry_t table_q[$];
  int     errors;

  blink_top #(.tick_div(TICK_DIV)) blink_top_i (
    .mck, .rst, .ca, .cdi, .cdo, .mrq_n, .ior_n, .crd_n, .cm1_n, .hlt_n, .kbmat,
    .ma, .ipce_n, .irce_n, .se1_n, .se2_n, .se3_n, .roe_n, .wrb_n, .intb_n, .pm1
  );

  initial begin
    mck = 1'b0;
    forever #(CLK_PERIOD / 2) mck = ~mck;
  end

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("ERROR %0t: %s gave %h, expected %h", $time, what, got, exp);
  endtask

  // One Z80 I/O cycle, strobe held for two clocks
  task automatic io_cycle(input logic rd, input logic ack, input logic [7:0] port,
                          input logic [7:0] hi, input logic [7:0] data,
                          output logic [7:0] rdata);
    @(posedge mck);
    #1;
    ca    = {hi, port};
    cdi   = data;
    crd_n = !rd;
    cm1_n = !ack;  // M1 with IORQ is interrupt acknowledge
    ior_n = 1'b0;
    repeat (2) @(posedge mck);
    #1;
    rdata = cdo;  // Latched value still driven
    ior_n = 1'b1;
    crd_n = 1'b1;
    cm1_n = 1'b1;
    @(posedge mck);
    #1;  // Idle clock, lets rd_end through
  endtask

  task automatic mem_read(input logic [7:0] hi, input logic [7:0] lo,
                          output logic [21:0] got_ma, output logic [4:0] got_en,
                          output logic [1:0] got_strb);
    @(posedge mck);
    #1;
    ca    = {hi, lo};
    mrq_n = 1'b0;
    crd_n = 1'b0;
    @(posedge mck);
    #1;
    got_ma   = ma;
    got_en   = {se3_n, se2_n, se1_n, irce_n, ipce_n};  // Bit 0 is ipce
    got_strb = {roe_n, wrb_n};
    mrq_n    = 1'b1;
    crd_n    = 1'b1;
  endtask

  task automatic wait_intb(input int max_cycles, output bit seen);
    seen = 1'b0;
    for (int i = 0; i < max_cycles && !seen; i++) begin
      @(posedge mck);
      #1;
      seen = !intb_n;
    end
  endtask

  // Column byte is the OR of every selected row
  function automatic logic [7:0] kbd_model(input logic [63:0] mat, input logic [7:0] rows);
    logic [7:0] acc;
    acc = 8'h00;
    for (int r = 0; r < 8; r++) begin
      if (rows[r])
        acc = acc | mat[8*r +: 8];
    end
    return acc;
  endfunction

  function automatic logic [7:0] tim0_model(input int ticks);
    return 8'(ticks % (int'(blink_pkg::TIM0_MAX) + 1));
  endfunction

  function automatic logic [7:0] tim1_model(input int ticks);
    return 8'((ticks / (int'(blink_pkg::TIM0_MAX) + 1)) % (int'(blink_pkg::TIM1_MAX) + 1));
  endfunction

  function automatic void add_entry(input op_e op, input logic [7:0] port, input logic [7:0] hi,
                                    input logic [7:0] data, input logic [24:0] exp);
    entry_t e;
    e.op   = op;
    e.port = port;
    e.hi   = hi;
    e.data = data;
    e.exp  = exp;
    table_q.push_back(e);
  endfunction

  function automatic void build_table();
    add_entry(OP_WR, blink_pkg::PORT_COM, 8'h00, 8'h00, '0);
    add_entry(OP_WR, blink_pkg::PORT_SR0_TIM0, 8'h00, 8'h05, '0);
    add_entry(OP_WR, blink_pkg::PORT_SR1_TIM1, 8'h00, 8'h41, '0);
    add_entry(OP_WR, blink_pkg::PORT_SR2_TIMM0, 8'h00, 8'h83, '0);
    add_entry(OP_WR, blink_pkg::PORT_SR3_TIMM1, 8'h00, 8'hC7, '0);
    add_entry(OP_MEM, 8'h34, 8'h12, 8'h00, {3'd0, 22'h001234});  // Boot ROM, ipce
    add_entry(OP_MEM, 8'h45, 8'h23, 8'h00, {3'd0, 22'h016345});  // SR0 upper half
    add_entry(OP_MEM, 8'h67, 8'h45, 8'h00, {3'd2, 22'h104567});  // Slot 1
    add_entry(OP_MEM, 8'hAB, 8'h89, 8'h00, {3'd3, 22'h20C9AB});  // Slot 2
    add_entry(OP_MEM, 8'hDC, 8'hFE, 8'h00, {3'd4, 22'h31FEDC});  // Slot 3
    add_entry(OP_WR, blink_pkg::PORT_COM, 8'h00, 8'(1 << blink_pkg::COM_RAMS), '0);
    add_entry(OP_MEM, 8'hBC, 8'h0A, 8'h00, {3'd1, 22'h080ABC});  // RAM bank 20h, irce
    add_entry(OP_MEM, 8'h45, 8'h23, 8'h00, {3'd0, 22'h016345});  // Untouched by RAMS
    add_entry(OP_KEY, blink_pkg::PORT_KBD, 8'h01, 8'h00, '0);
    add_entry(OP_KEY, blink_pkg::PORT_KBD, 8'h81, 8'h00, '0);
    add_entry(OP_KEY, blink_pkg::PORT_KBD, 8'h5A, 8'h00, '0);
    add_entry(OP_KEY, blink_pkg::PORT_KBD, 8'hFF, 8'h00, '0);
    add_entry(OP_KEY, blink_pkg::PORT_KBD, 8'h00, 8'h00, '0);
    add_entry(OP_WR, blink_pkg::PORT_COM, 8'h00, 8'(1 << blink_pkg::COM_RESTIM), '0);
    add_entry(OP_WR, blink_pkg::PORT_COM, 8'h00, 8'h00, '0);
    add_entry(OP_TICKS, 8'h00, 8'h00, 8'd250, '0);
    add_entry(OP_RD, blink_pkg::PORT_SR0_TIM0, 8'h00, 8'h00, 25'(tim0_model(250)));
    add_entry(OP_RD, blink_pkg::PORT_SR1_TIM1, 8'h00, 8'h00, 25'(tim1_model(250)));
    add_entry(OP_WR, blink_pkg::PORT_COM, 8'h00, 8'(1 << blink_pkg::COM_RESTIM), '0);
    add_entry(OP_RD, blink_pkg::PORT_SR0_TIM0, 8'h00, 8'h00, 25'h0);
    add_entry(OP_RD, blink_pkg::PORT_SR1_TIM1, 8'h00, 8'h00, 25'h0);
  endfunction

  initial begin
    entry_t      e;
    logic [7:0]  rdata;
    logic [7:0]  exp_kbd;
    logic [21:0] got_ma;
    logic [4:0]  got_en;
    logic [4:0]  exp_en;
    logic [1:0]  got_strb;
    bit          seen;
    void'($urandom(94));
    errors = 0;
    build_table();
    rst   = 1'b1;
    ca    = '0;
    cdi   = 8'h5A;
    mrq_n = 1'b1;
    ior_n = 1'b1;
    crd_n = 1'b1;
    cm1_n = 1'b1;
    hlt_n = 1'b1;
    kbmat = '0;
    repeat (4) @(posedge mck);
    #1;
    rst = 1'b0;
    if (cdo !== 8'h5A)
      report_mismatch("cdo echo after reset", 32'(cdo), 32'h5A);
    if (intb_n !== 1'b1)
      report_mismatch("intb_n after reset", 32'(intb_n), 32'h1);

    foreach (table_q[i]) begin
      e = table_q[i];
      case (e.op)
        OP_WR: io_cycle(1'b0, 1'b0, e.port, e.hi, e.data, rdata);
        OP_RD: begin
          io_cycle(1'b1, 1'b0, e.port, e.hi, 8'h00, rdata);
          if (rdata !== e.exp[7:0])
            report_mismatch($sformatf("read of port %h", e.port), 32'(rdata), 32'(e.exp[7:0]));
        end
        OP_MEM: begin
          mem_read(e.hi, e.port, got_ma, got_en, got_strb);
          exp_en = ~(5'b00001 << e.exp[24:22]);  // Only one enable low
          if (got_ma !== e.exp[21:0])
            report_mismatch($sformatf("ma for %h%h", e.hi, e.port), 32'(got_ma),
                            32'(e.exp[21:0]));
          if (got_en !== exp_en)
            report_mismatch($sformatf("enables for %h%h", e.hi, e.port), 32'(got_en),
                            32'(exp_en));
          if (got_strb !== 2'b01)
            report_mismatch("roe_n and wrb_n on read", 32'(got_strb), 32'h1);
        end
        OP_KEY: begin
          kbmat = {$urandom(), $urandom()};
          io_cycle(1'b1, 1'b0, e.port, e.hi, 8'h00, rdata);
          exp_kbd = kbd_model(kbmat, e.hi);
          if (rdata !== exp_kbd)
            report_mismatch($sformatf("KBD rows %h", e.hi), 32'(rdata), 32'(exp_kbd));
        end
        default: begin
          // Next read samples exactly data x TICK_DIV counting edges after the COM write
          repeat (int'(e.data) * TICK_DIV - 3) @(posedge mck);
          #1;
        end
      endcase
    end

    // Timer interrupt on 5 ms events
    io_cycle(1'b0, 1'b0, blink_pkg::PORT_COM, 8'h00, 8'h00, rdata);
    io_cycle(1'b0, 1'b0, blink_pkg::PORT_TMK_TSTA, 8'h00, 8'h01, rdata);
    io_cycle(1'b0, 1'b0, blink_pkg::PORT_INT_STA, 8'h00, 8'h03, rdata);  // GINT, TIME
    wait_intb(3 * TICK_DIV, seen);
    if (!seen) begin
      errors++;
      $display("Unmasked timer tick never pulled intb_n low");
    end
    io_cycle(1'b1, 1'b0, blink_pkg::PORT_INT_STA, 8'h00, 8'h00, rdata);
    if (rdata !== 8'h04)
      report_mismatch("STA after tick", 32'(rdata), 32'h04);
    io_cycle(1'b0, 1'b1, 8'h00, 8'h00, 8'h00, rdata);  // Release intb for the next tick
    wait_intb(3 * TICK_DIV, seen);
    if (!seen) begin
      errors++;
      $display("Second timer tick never pulled intb_n low");
    end
    io_cycle(1'b0, 1'b0, blink_pkg::PORT_TMK_TSTA, 8'h00, 8'h00, rdata);  // No new events
    io_cycle(1'b0, 1'b0, blink_pkg::PORT_ACK, 8'h00, 8'h04, rdata);
    io_cycle(1'b1, 1'b0, blink_pkg::PORT_INT_STA, 8'h00, 8'h00, rdata);
    if (rdata !== 8'h00)
      report_mismatch("STA after ACK", 32'(rdata), 32'h00);
    if (intb_n !== 1'b0)
      report_mismatch("intb_n before intack", 32'(intb_n), 32'h0);
    io_cycle(1'b0, 1'b1, 8'h00, 8'h00, 8'h00, rdata);
    if (intb_n !== 1'b1)
      report_mismatch("intb_n after intack", 32'(intb_n), 32'h1);

    // Halt right after an interrupt, well before the next tick
    io_cycle(1'b0, 1'b0, blink_pkg::PORT_TMK_TSTA, 8'h00, 8'h01, rdata);
    wait_intb(3 * TICK_DIV, seen);
    io_cycle(1'b0, 1'b1, 8'h00, 8'h00, 8'h00, rdata);
    hlt_n = 1'b0;
    repeat (2) @(posedge mck);
    for (int i = 0; i < 3; i++) begin
      @(posedge mck);
      #1;  // mck high here, so pm1 shows clk_run
      if (pm1 !== 1'b0)
        report_mismatch("pm1 while halted", 32'(pm1), 32'h0);
    end
    wait_intb(TICK_DIV + 4, seen);
    if (!seen) begin
      errors++;
      $display("No timer interrupt arrived while the CPU was halted");
    end
    @(posedge mck);
    #1;
    if (pm1 !== 1'b1)
      report_mismatch("pm1 after interrupt", 32'(pm1), 32'h1);
    hlt_n = 1'b1;

    // Snooze on empty keyboard, GINT off
    io_cycle(1'b0, 1'b0, blink_pkg::PORT_INT_STA, 8'h00, 8'h80, rdata);
    io_cycle(1'b0, 1'b1, 8'h00, 8'h00, 8'h00, rdata);
    kbmat = '0;
    io_cycle(1'b1, 1'b0, blink_pkg::PORT_KBD, 8'hFF, 8'h00, rdata);
    if (rdata !== 8'h00)
      report_mismatch("KBD with no key", 32'(rdata), 32'h00);
    for (int i = 0; i < 3; i++) begin
      @(posedge mck);
      #1;
      if (pm1 !== 1'b0)
        report_mismatch("pm1 while snoozing", 32'(pm1), 32'h0);
    end
    kbmat[29] = 1'b1;  // Row 3, column 5
    seen = 1'b0;
    for (int i = 0; i < 4 && !seen; i++) begin
      @(posedge mck);
      #1;
      seen = pm1;
    end
    if (!seen) begin
      errors++;
      $display("pm1 stayed stopped after a key press");
    end
    if (intb_n !== 1'b0)
      report_mismatch("intb_n after key press", 32'(intb_n), 32'h0);

    $display("Table entries: %0d, errors: %0d", table_q.size(), errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Table time plus the long tick waits
  initial begin
    int limit;
    #1;
    limit = (table_q.size() * 12 + 300 * TICK_DIV) * CLK_PERIOD;
    #(limit);
    $display("Timeout: tests did not finish within %0d time units", limit);
    $display("Verification failed");
    $finish;
  end

endmodule
